//--- src/aes_pkg.sv
// aes shared package: widths, round encoding, control struct and GF(2^8) helpers
package aes_pkg;

  //--------------------------------------------------------------------
  // widths and round counts
  //--------------------------------------------------------------------
  localparam int unsigned BLOCK_W = 128;
  localparam int unsigned WORD_W  = 32;
  localparam int unsigned ROUND_W = 4;

  // rounds per key length
  localparam logic [ROUND_W-1:0] AES128_ROUNDS = 4'd10;
  localparam logic [ROUND_W-1:0] AES256_ROUNDS = 4'd14;

  //--------------------------------------------------------------------
  // data types
  //--------------------------------------------------------------------
  // block and round key, byte 0 in the msbs
  typedef logic [BLOCK_W-1:0] block_t;

  // one state column, row 0 in the msbs
  typedef logic [WORD_W-1:0] word_t;

  // state as four columns, column 0 leftmost
  typedef word_t [0:3] state_t;

  // which transform the round logic applies
  typedef enum logic [1:0] {
    INIT_ROUND  = 2'd0,
    MAIN_ROUND  = 2'd1,
    FINAL_ROUND = 2'd2
  } round_type_e;

  // controller to datapath steering
  typedef struct packed {
    logic        load_block;
    logic        sub_word_we;
    logic [1:0]  sword_idx;
    logic        round_we;
    round_type_e round_type;
  } round_ctrl_t;

  //--------------------------------------------------------------------
  // GF(2^8) multiply, polynomial x^8 + x^4 + x^3 + x + 1
  //--------------------------------------------------------------------
  // xtime, reduce by 0x1b when the top bit falls out
  function automatic logic [7:0] gm2(input logic [7:0] op);
    return {op[6:0], 1'b0} ^ (8'h1b & {8{op[7]}});
  endfunction

  // times 3 is times 2 plus the operand
  function automatic logic [7:0] gm3(input logic [7:0] op);
    return gm2(op) ^ op;
  endfunction

endpackage

//--- src/aes_sbox_word.sv
// aes forward s-box applied to all four bytes of one state column
`timescale 1ns/1ps

module aes_sbox_word (
  input  aes_pkg::word_t sbox_in,
  output aes_pkg::word_t sbox_out
);

  //--------------------------------------------------------------------
  // forward substitution table, row = high nibble
  //--------------------------------------------------------------------
  localparam logic [7:0] SBOX [0:255] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  //--------------------------------------------------------------------
  // four parallel lookups, one per row byte
  //--------------------------------------------------------------------
  always_comb
  begin
    for (int b = 0; b < 4; b++)
    begin
      // byte b sits at bits 31-8b down to 24-8b
      sbox_out[31 - 8*b -: 8] = SBOX[sbox_in[31 - 8*b -: 8]];
    end
  end

endmodule

//--- src/aes_round_ctrl.sv
// aes round controller that latches the key length and runs the round FSM and counters
`timescale 1ns/1ps

module aes_round_ctrl (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         next,
  input  logic                         keylen,
  output aes_pkg::round_ctrl_t         ctrl,
  output logic [aes_pkg::ROUND_W-1:0]  key_round,
  output logic                         ready
);

  //--------------------------------------------------------------------
  // FSM encoding
  //--------------------------------------------------------------------
  // idle waits, init steps past round 0, sub runs 4 words, mix ends round
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_INIT = 2'd1,
    ST_SUB  = 2'd2,
    ST_MIX  = 2'd3
  } ctrl_state_e;

  ctrl_state_e                   state_q;
  logic [1:0]                    sword_q;
  logic [aes_pkg::ROUND_W-1:0]   round_q;
  logic [aes_pkg::ROUND_W-1:0]   limit_q;
  logic                          final_round;

  // last round reached so MixColumns is skipped
  assign final_round = (round_q == limit_q);

  //--------------------------------------------------------------------
  // sequencing
  //--------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_q <= ST_IDLE;
      sword_q <= 2'd0;
      round_q <= '0;
      limit_q <= aes_pkg::AES128_ROUNDS;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          // start with the round 0 key added on this same edge
          if (next)
          begin
            limit_q <= keylen ? aes_pkg::AES256_ROUNDS : aes_pkg::AES128_ROUNDS;
            state_q <= ST_INIT;
          end
        end
        ST_INIT:
        begin
          round_q <= round_q + 1'b1;
          state_q <= ST_SUB;
        end
        ST_SUB:
        begin
          // counter wraps to 0 after word 3
          sword_q <= sword_q + 1'b1;
          if (sword_q == 2'd3)
          begin
            state_q <= ST_MIX;
          end
        end
        ST_MIX:
        begin
          if (final_round)
          begin
            // back to key 0 for the next block
            round_q <= '0;
            state_q <= ST_IDLE;
          end
          else
          begin
            round_q <= round_q + 1'b1;
            state_q <= ST_SUB;
          end
        end
        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  //--------------------------------------------------------------------
  // decode towards the datapath
  //--------------------------------------------------------------------
  always_comb
  begin
    ctrl.load_block  = (state_q == ST_IDLE) && next;
    ctrl.sub_word_we = (state_q == ST_SUB);
    ctrl.sword_idx   = sword_q;
    ctrl.round_we    = (state_q == ST_MIX);
    ctrl.round_type  = aes_pkg::INIT_ROUND;
    if (state_q == ST_MIX)
    begin
      ctrl.round_type = final_round ? aes_pkg::FINAL_ROUND : aes_pkg::MAIN_ROUND;
    end
  end

  // key index follows the round counter
  assign key_round = round_q;
  assign ready     = (state_q == ST_IDLE);

  //--------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------
  // a started block keeps ready low for at least the shortest run
  a_busy_after_load: assert property (@(posedge clk) disable iff (!reset_n)
    ctrl.load_block |=> !ready [*(5 * aes_pkg::AES128_ROUNDS + 1)]);

  // idle engine offers round key 0 for the next start
  a_key0_when_ready: assert property (@(posedge clk) disable iff (!reset_n)
    ready |-> (key_round == '0));

  // word counter rests at 0 outside the sub state
  a_sword_in_sub: assert property (@(posedge clk) disable iff (!reset_n)
    (state_q != ST_SUB) |-> (sword_q == 2'd0));

endmodule

//--- src/aes_round_datapath.sv
// aes round datapath holding the state register and the init, main and final round transforms
`timescale 1ns/1ps

module aes_round_datapath (
  input  logic                 clk,
  input  logic                 reset_n,
  input  aes_pkg::round_ctrl_t ctrl,
  input  aes_pkg::block_t      block,
  input  aes_pkg::block_t      round_key,
  input  aes_pkg::word_t       sbox_out,
  output aes_pkg::word_t       sbox_in,
  output aes_pkg::block_t      new_block
);

  //--------------------------------------------------------------------
  // round helpers
  //--------------------------------------------------------------------
  // row r rotates left by r columns
  function automatic aes_pkg::state_t shift_rows(input aes_pkg::state_t s);
    aes_pkg::state_t t;
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        t[c][31 - 8*r -: 8] = s[(c + r) % 4][31 - 8*r -: 8];
      end
    end
    return t;
  endfunction

  // standard MixColumns on one column
  function automatic aes_pkg::word_t mix_column(input aes_pkg::word_t w);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    a0 = w[31:24];
    a1 = w[23:16];
    a2 = w[15:8];
    a3 = w[7:0];
    return {aes_pkg::gm2(a0) ^ aes_pkg::gm3(a1) ^ a2 ^ a3,
            a0 ^ aes_pkg::gm2(a1) ^ aes_pkg::gm3(a2) ^ a3,
            a0 ^ a1 ^ aes_pkg::gm2(a2) ^ aes_pkg::gm3(a3),
            aes_pkg::gm3(a0) ^ a1 ^ a2 ^ aes_pkg::gm2(a3)};
  endfunction

  //--------------------------------------------------------------------
  // state and next-state logic
  //--------------------------------------------------------------------
  aes_pkg::state_t state_q;
  aes_pkg::state_t shifted;
  aes_pkg::state_t mixed;
  aes_pkg::state_t pre_key;
  aes_pkg::state_t state_next;

  always_comb
  begin
    shifted = shift_rows(state_q);
    for (int c = 0; c < 4; c++)
    begin
      mixed[c] = mix_column(shifted[c]);
    end

    // pick what goes into AddRoundKey
    case (ctrl.round_type)
      aes_pkg::INIT_ROUND:  pre_key = block;
      aes_pkg::MAIN_ROUND:  pre_key = mixed;
      aes_pkg::FINAL_ROUND: pre_key = shifted;
      default:              pre_key = mixed;
    endcase

    // one shared AddRoundKey for every round type
    state_next = pre_key ^ round_key;
  end

  // SubBytes feed of one column per cycle
  assign sbox_in = state_q[ctrl.sword_idx];

  // whole block on a round write, one column on a substitution
  always_ff @(posedge clk)
  begin
    if (ctrl.load_block || ctrl.round_we)
    begin
      state_q <= state_next;
    end
    else if (ctrl.sub_word_we)
    begin
      state_q[ctrl.sword_idx] <= sbox_out;
    end
  end

  assign new_block = state_q;

  //--------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------
  // at most one writer of the state per cycle
  a_single_writer: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot0({ctrl.load_block, ctrl.sub_word_we, ctrl.round_we}));

  // every round write comes right after the fourth substituted word
  a_round_after_sub: assert property (@(posedge clk) disable iff (!reset_n)
    ctrl.round_we |-> $past(ctrl.sub_word_we && (ctrl.sword_idx == 2'd3)));

endmodule

//--- src/aes_encipher_core.sv
// aes encipher core: ties round controller, round datapath and s-box together
`timescale 1ns/1ps

module aes_encipher_core (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         next,
  input  logic                         keylen,
  input  aes_pkg::block_t              block,
  input  aes_pkg::block_t              round_key,
  output logic [aes_pkg::ROUND_W-1:0]  key_round,
  output aes_pkg::block_t              new_block,
  output logic                         ready
);

  //--------------------------------------------------------------------
  // internal nets
  //--------------------------------------------------------------------
  aes_pkg::round_ctrl_t ctrl;
  aes_pkg::word_t       sbox_in;
  aes_pkg::word_t       sbox_out;

  // sequencing, key index and ready
  aes_round_ctrl u_ctrl (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .keylen    (keylen),
    .ctrl      (ctrl),
    .key_round (key_round),
    .ready     (ready)
  );

  // state register and round transforms
  aes_round_datapath u_datapath (
    .clk       (clk),
    .reset_n   (reset_n),
    .ctrl      (ctrl),
    .block     (block),
    .round_key (round_key),
    .sbox_out  (sbox_out),
    .sbox_in   (sbox_in),
    .new_block (new_block)
  );

  // combinational SubBytes for one column
  aes_sbox_word u_sbox (
    .sbox_in  (sbox_in),
    .sbox_out (sbox_out)
  );

endmodule

//--- dv/aes_ref_model.svh
// aes reference model: s-box from field inverse, key schedule and block encryption
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// round keys 0 to 14, key 0 at index 0
typedef logic [14:0][127:0] key_sched_t;

//----------------------------------------------------------------------
// GF(2^8) arithmetic
//----------------------------------------------------------------------
// xtime with the 0x11b reduction
function automatic logic [7:0] gm2(input logic [7:0] a);
  logic [7:0] r;
  r = {a[6:0], 1'b0};
  if (a[7])
  begin
    r = r ^ 8'h1b;
  end
  return r;
endfunction

function automatic logic [7:0] gm3(input logic [7:0] a);
  return gm2(a) ^ a;
endfunction

// shift and add multiply
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] acc;
  logic [7:0] p;
  acc = 8'h00;
  p   = a;
  for (int i = 0; i < 8; i++)
  begin
    if (b[i])
    begin
      acc = acc ^ p;
    end
    p = gm2(p);
  end
  return acc;
endfunction

// inverse as a^254, zero stays zero
function automatic logic [7:0] gf_inv(input logic [7:0] a);
  logic [7:0] r;
  logic [7:0] base;
  logic [7:0] e;
  r    = 8'h01;
  base = a;
  e    = 8'd254;
  while (e != 0)
  begin
    if (e[0])
    begin
      r = gf_mul(r, base);
    end
    base = gf_mul(base, base);
    e    = e >> 1;
  end
  return r;
endfunction

// inverse, then the affine map with constant 0x63
function automatic logic [7:0] sbox_byte(input logic [7:0] a);
  logic [7:0] b;
  b = gf_inv(a);
  return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]} ^ {b[3:0], b[7:4]} ^ 8'h63;
endfunction

function automatic logic [31:0] sub_word(input logic [31:0] w);
  return {sbox_byte(w[31:24]), sbox_byte(w[23:16]), sbox_byte(w[15:8]), sbox_byte(w[7:0])};
endfunction

//----------------------------------------------------------------------
// key schedule, key in the msbs for aes-128
//----------------------------------------------------------------------
function automatic key_sched_t expand_key(input logic [255:0] key, input logic kl);
  logic [31:0] w [0:59];
  logic [31:0] t;
  logic [7:0]  rcon;
  key_sched_t  ks;
  int          nk;
  int          nw;
  nk   = kl ? 8 : 4;
  nw   = kl ? 60 : 44;
  rcon = 8'h01;
  ks   = '0;
  for (int i = 0; i < nk; i++)
  begin
    w[i] = key[255 - 32*i -: 32];
  end
  for (int i = nk; i < nw; i++)
  begin
    t = w[i-1];
    if (i % nk == 0)
    begin
      // RotWord, SubWord, then the round constant
      t    = sub_word({t[23:0], t[31:24]}) ^ {rcon, 24'h0};
      rcon = gm2(rcon);
    end
    else if (nk == 8 && i % nk == 4)
    begin
      t = sub_word(t);
    end
    w[i] = w[i-nk] ^ t;
  end
  for (int r = 0; r < nw / 4; r++)
  begin
    ks[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
  end
  return ks;
endfunction

//----------------------------------------------------------------------
// full encryption, byte i is row i%4 of column i/4
//----------------------------------------------------------------------
function automatic logic [127:0] aes_encrypt_ref(input logic [127:0] pt,
                                                 input key_sched_t ks, input logic kl);
  logic [7:0]   s [0:15];
  logic [7:0]   t [0:15];
  logic [127:0] blk;
  int           nr;
  nr  = kl ? 14 : 10;
  blk = pt ^ ks[0];
  for (int r = 1; r <= nr; r++)
  begin
    for (int i = 0; i < 16; i++)
    begin
      s[i] = sbox_byte(blk[127 - 8*i -: 8]);
    end
    // row i%4 moves left by its row number
    for (int i = 0; i < 16; i++)
    begin
      t[i] = s[(i + 4*(i % 4)) % 16];
    end
    for (int c = 0; c < 4; c++)
    begin
      if (r != nr)
      begin
        s[4*c]   = gm2(t[4*c]) ^ gm3(t[4*c+1]) ^ t[4*c+2] ^ t[4*c+3];
        s[4*c+1] = t[4*c] ^ gm2(t[4*c+1]) ^ gm3(t[4*c+2]) ^ t[4*c+3];
        s[4*c+2] = t[4*c] ^ t[4*c+1] ^ gm2(t[4*c+2]) ^ gm3(t[4*c+3]);
        s[4*c+3] = gm3(t[4*c]) ^ t[4*c+1] ^ t[4*c+2] ^ gm2(t[4*c+3]);
      end
      else
      begin
        for (int k = 0; k < 4; k++)
        begin
          s[4*c+k] = t[4*c+k];
        end
      end
    end
    for (int i = 0; i < 16; i++)
    begin
      blk[127 - 8*i -: 8] = s[i];
    end
    blk = blk ^ ks[r];
  end
  return blk;
endfunction

`endif

//--- dv/tb_aes_encipher.sv
// testbench for the aes encipher core: known vectors, random blocks, busy start, result hold
`timescale 1ns/1ps

module tb_aes_encipher;

  `include "aes_ref_model.svh"

  // reset, two vectors, 40 random, busy and hold
  localparam int NUM_TESTS   = 45;
  // longest block takes 71 cycles plus start overhead
  localparam int CYCLE_LIMIT = NUM_TESTS * 80 + 200;

  logic                        clk = 1'b0;
  logic                        reset_n;
  logic                        next;
  logic                        keylen;
  aes_pkg::block_t             block;
  aes_pkg::block_t             round_key;
  logic [aes_pkg::ROUND_W-1:0] key_round;
  aes_pkg::block_t             new_block;
  logic                        ready;

  key_sched_t sched      = '0;
  integer     seed       = 32'haf5e8a88;
  int         cycle_cnt  = 0;
  int         started    = 0;
  int         done_cnt   = 0;
  int         pass_cnt   = 0;
  int         fail_cnt   = 0;
  logic       ready_prev = 1'b1;

  // pending results, pushed at start, popped when ready rises
  aes_pkg::block_t exp_q[$];
  int              lat_q[$];
  int              start_q[$];
  string           name_q[$];

  aes_encipher_core UUT (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .keylen    (keylen),
    .block     (block),
    .round_key (round_key),
    .key_round (key_round),
    .new_block (new_block),
    .ready     (ready)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // round key follows the published index
  always @(negedge clk)
  begin
    round_key = sched[key_round];
  end

  //--------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------
  task automatic report_test(input string name, input logic ok);
    if (ok)
    begin
      pass_cnt++;
      $display("test %-22s ok", name);
    end
    else
    begin
      fail_cnt++;
      $display("test %-22s FAILED", name);
    end
  endtask

  // schedule first, then one start strobe
  task automatic start_block(input aes_pkg::block_t pt, input logic [255:0] key,
                             input logic kl, input aes_pkg::block_t exp, input string name);
    @(negedge clk);
    sched = expand_key(key, kl);
    @(negedge clk);
    block  = pt;
    keylen = kl;
    next   = 1'b1;
    exp_q.push_back(exp);
    lat_q.push_back(1 + 5 * (kl ? 14 : 10));
    start_q.push_back(cycle_cnt + 1);
    name_q.push_back(name);
    started++;
    @(negedge clk);
    next = 1'b0;
  endtask

  task automatic run_block(input aes_pkg::block_t pt, input logic [255:0] key,
                           input logic kl, input aes_pkg::block_t exp, input string name);
    start_block(pt, key, kl, exp, name);
    wait (done_cnt == started);
  endtask

  // idle engine must keep the last ciphertext
  task automatic check_hold(input int cycles, input aes_pkg::block_t exp);
    logic ok;
    ok = 1'b1;
    repeat (cycles)
    begin
      @(negedge clk);
      assert (ready === 1'b1)
      else
      begin
        $display("** Error at %0t: ready expected 1 got %b", $time, ready);
        ok = 1'b0;
      end
      assert (new_block === exp)
      else
      begin
        $display("** Error at %0t: new_block expected %h got %h", $time, exp, new_block);
        ok = 1'b0;
      end
    end
    report_test("result holds", ok);
  endtask

  //--------------------------------------------------------------------
  // comparison on the rising edge of ready
  //--------------------------------------------------------------------
  always @(negedge clk)
  begin : compare_result
    aes_pkg::block_t exp;
    int              lat;
    int              exp_lat;
    logic            ok;
    if (ready && !ready_prev && exp_q.size() > 0)
    begin
      exp     = exp_q.pop_front();
      exp_lat = lat_q.pop_front();
      lat     = cycle_cnt - start_q.pop_front();
      ok      = 1'b1;
      assert (new_block === exp)
      else
      begin
        $display("** Error at %0t: new_block expected %h got %h", $time, exp, new_block);
        ok = 1'b0;
      end
      assert (lat == exp_lat)
      else
      begin
        $display("** Error at %0t: ready latency expected %0d got %0d", $time, exp_lat, lat);
        ok = 1'b0;
      end
      report_test(name_q.pop_front(), ok);
      done_cnt++;
    end
    ready_prev = ready;
  end

  //--------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------
  initial
  begin : stimulus
    aes_pkg::block_t pt;
    aes_pkg::block_t exp_ct;
    logic [255:0]    key;
    logic            kl;
    logic            ok;
    reset_n   = 1'b0;
    next      = 1'b0;
    keylen    = 1'b0;
    block     = '0;
    round_key = '0;
    repeat (8) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    ok = 1'b1;
    assert (ready === 1'b1)
    else
    begin
      $display("** Error at %0t: ready expected 1 got %b", $time, ready);
      ok = 1'b0;
    end
    assert (key_round === '0)
    else
    begin
      $display("** Error at %0t: key_round expected 0 got %0d", $time, key_round);
      ok = 1'b0;
    end
    report_test("reset state", ok);

    // FIPS-197 appendix C vectors
    run_block(128'h00112233445566778899aabbccddeeff,
              {128'h000102030405060708090a0b0c0d0e0f, 128'h0}, 1'b0,
              128'h69c4e0d86a7b0430d8cdb78070b4c55a, "fips-197 aes-128");
    run_block(128'h00112233445566778899aabbccddeeff,
              256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f, 1'b1,
              128'h8ea2b7ca516745bfeafc49904b496089, "fips-197 aes-256");

    // alternating key lengths
    for (int i = 0; i < 40; i++)
    begin
      kl = (i % 2 == 1);
      for (int j = 0; j < 4; j++)
      begin
        pt = {pt[95:0], $random(seed)};
      end
      for (int j = 0; j < 8; j++)
      begin
        key = {key[223:0], $random(seed)};
      end
      run_block(pt, key, kl, aes_encrypt_ref(pt, expand_key(key, kl), kl),
                $sformatf("random %0d aes-%0d", i, kl ? 256 : 128));
    end

    // stray start with other data mid-run
    pt     = {$random(seed), $random(seed), $random(seed), $random(seed)};
    key    = {pt, ~pt};
    exp_ct = aes_encrypt_ref(pt, expand_key(key, 1'b1), 1'b1);
    start_block(pt, key, 1'b1, exp_ct, "next while busy");
    repeat (10) @(negedge clk);
    block  = ~pt;
    keylen = 1'b0;
    next   = 1'b1;
    @(negedge clk);
    next = 1'b0;
    wait (done_cnt == started);
    check_hold(12, exp_ct);

    $display("summary: %0d tests, %0d ok, %0d failed", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    if (fail_cnt == 0)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

  // run limit
  initial
  begin
    wait (cycle_cnt >= CYCLE_LIMIT);
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+dv
src/aes_pkg.sv
src/aes_sbox_word.sv
src/aes_round_ctrl.sv
src/aes_round_datapath.sv
src/aes_encipher_core.sv
dv/tb_aes_encipher.sv

//--- Bender.yml
package:
  name: aes_encipher

sources:
  - src/aes_pkg.sv
  - src/aes_sbox_word.sv
  - src/aes_round_ctrl.sv
  - src/aes_round_datapath.sv
  - src/aes_encipher_core.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_aes_encipher.sv
